/* files.f */
logic/gamePkg.sv
logic/keyPkg.sv
logic/keyDecoder.sv
logic/fighterUnit.sv
logic/combatJudge.sv
logic/fighterArena.sv
tests/fighterArenaTb.sv

/* logic/combatJudge.sv */
// ================================================
// strike range check, hit and block decision,
// knockback direction, game-over and winner latch
// ================================================
`timescale 1ns/1ps

module combatJudge (
	input  logic Clk,
	input  logic rstN,
	input  logic frameTick,
	input  logic [9:0] posX [gamePkg::numPlayers],
	input  logic [5:0] height [gamePkg::numPlayers],
	input  gamePkg::stanceT stance [gamePkg::numPlayers],
	input  logic strike [gamePkg::numPlayers],
	input  logic ko [gamePkg::numPlayers],
	output logic hit [gamePkg::numPlayers],
	output logic blocked [gamePkg::numPlayers],
	output logic pushLeft [gamePkg::numPlayers],
	output logic gameOver,
	output logic winner
);

	logic [9:0] gap;
	logic inRange;
	logic grounded;  // nobody in the air

	always_comb begin
		gap = (posX[0] >= posX[1]) ? posX[0] - posX[1] : posX[1] - posX[0];
		inRange = (gap <= gamePkg::reach);
		grounded = (height[0] == 6'd0) && (height[1] == 6'd0);
	end

	// ================================================
	// per-tick decisions
	// ================================================
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int v = 0; v < gamePkg::numPlayers; v++) begin
				hit[v]      <= 1'b0;
				blocked[v]  <= 1'b0;
				pushLeft[v] <= 1'b0;
			end
			gameOver <= 1'b0;
			winner   <= 1'b0;
		end else if (frameTick) begin
			// v is the victim, the other index the attacker
			for (int v = 0; v < gamePkg::numPlayers; v++) begin
				hit[v] <= !gameOver && strike[gamePkg::numPlayers-1-v] && inRange && grounded;
				blocked[v]  <= (stance[v] == gamePkg::crouch);
				pushLeft[v] <= (posX[v] < posX[gamePkg::numPlayers-1-v]);
			end

			// double KO goes to player 0
			if (!gameOver && (ko[0] || ko[1])) begin
				gameOver <= 1'b1;
				winner   <= ko[0] && !ko[1];
			end
		end
	end

endmodule

/* logic/fighterArena.sv */
// ================================================
// top level: key decoder, two fighters, judge
// ================================================
`timescale 1ns/1ps

module fighterArena (
	input  logic Clk,
	input  logic rstN,
	input  logic frameTick,  // one pulse per frame
	input  logic keyReq,
	input  keyPkg::keyCodeT keyCode [keyPkg::keySlots],
	output logic keyAck,
	output logic [9:0] posX [gamePkg::numPlayers],
	output logic [5:0] height [gamePkg::numPlayers],
	output gamePkg::stanceT stance [gamePkg::numPlayers],
	output logic [7:0] health [gamePkg::numPlayers],
	output logic gameOver,
	output logic winner
);

	// decoder to fighters
	logic actLeft [gamePkg::numPlayers];
	logic actRight [gamePkg::numPlayers];
	logic actJump [gamePkg::numPlayers];
	logic actCrouch [gamePkg::numPlayers];
	logic actPunch [gamePkg::numPlayers];

	// fighters and judge
	logic strike [gamePkg::numPlayers];
	logic ko [gamePkg::numPlayers];
	logic hit [gamePkg::numPlayers];
	logic blocked [gamePkg::numPlayers];
	logic pushLeft [gamePkg::numPlayers];

	keyDecoder decoder (
		.Clk      (Clk),
		.rstN     (rstN),
		.keyReq   (keyReq),
		.keyCode  (keyCode),
		.keyAck   (keyAck),
		.actLeft  (actLeft),
		.actRight (actRight),
		.actJump  (actJump),
		.actCrouch(actCrouch),
		.actPunch (actPunch)
	);

	for (genvar i = 0; i < gamePkg::numPlayers; i++) begin : genFighter
		fighterUnit #(.homeX(gamePkg::startX[i])) unit (
			.Clk      (Clk),
			.rstN     (rstN),
			.frameTick(frameTick),
			.actLeft  (actLeft[i]),
			.actRight (actRight[i]),
			.actJump  (actJump[i]),
			.actCrouch(actCrouch[i]),
			.actPunch (actPunch[i]),
			.hit      (hit[i]),
			.blocked  (blocked[i]),
			.pushLeft (pushLeft[i]),
			.gameOver (gameOver),
			.posX     (posX[i]),
			.height   (height[i]),
			.stance   (stance[i]),
			.health   (health[i]),
			.strike   (strike[i]),
			.ko       (ko[i])
		);
	end

	combatJudge judge (
		.Clk      (Clk),
		.rstN     (rstN),
		.frameTick(frameTick),
		.posX     (posX),
		.height   (height),
		.stance   (stance),
		.strike   (strike),
		.ko       (ko),
		.hit      (hit),
		.blocked  (blocked),
		.pushLeft (pushLeft),
		.gameOver (gameOver),
		.winner   (winner)
	);

endmodule

/* logic/fighterUnit.sv */
// ================================================
// one fighter: stance FSM, walk, jump arc,
// knockback and health bookkeeping
// ================================================
`timescale 1ns/1ps

module fighterUnit #(
	parameter logic [9:0] homeX = gamePkg::startX[0]
) (
	input  logic Clk,
	input  logic rstN,
	input  logic frameTick,
	input  logic actLeft,
	input  logic actRight,
	input  logic actJump,
	input  logic actCrouch,
	input  logic actPunch,
	input  logic hit,
	input  logic blocked,
	input  logic pushLeft,
	input  logic gameOver,
	output logic [9:0] posX,
	output logic [5:0] height,
	output gamePkg::stanceT stance,
	output logic [7:0] health,
	output logic strike,
	output logic ko
);

	logic [3:0] frameCnt;  // frames left in jump or punch
	logic moveLeft, moveRight;
	logic idle, startWalk, canWalk;
	logic [9:0] nextX;
	logic [7:0] damage, nextHealth;

	// one step along x, held inside the walls
	function automatic logic [9:0] stepX(input logic [9:0] x, input logic [9:0] step,
			input logic left);
		if (left)
			return (x < gamePkg::xMin + step) ? gamePkg::xMin : x - step;
		else
			return (x + step > gamePkg::xMax) ? gamePkg::xMax : x + step;
	endfunction

	assign strike = (stance == gamePkg::punch) && (frameCnt == gamePkg::punchFrames - 4'd1);
	assign ko = (health == 8'd0);

	always_comb begin
		moveLeft  = actLeft & ~actRight;
		moveRight = actRight & ~actLeft;
		idle = (stance == gamePkg::stand) || (stance == gamePkg::walk)
			|| (stance == gamePkg::crouch);
		// walk loses to punch, jump and crouch
		startWalk = idle && !actPunch && !actJump && !actCrouch && (moveLeft || moveRight);
		canWalk = startWalk || ((stance == gamePkg::jump) && (moveLeft || moveRight));

		nextX = posX;
		if (hit && !blocked)
			nextX = stepX(posX, gamePkg::knockStep, pushLeft);  // knockback beats walking
		else if (canWalk)
			nextX = stepX(posX, gamePkg::walkStep, moveLeft);

		damage = blocked ? gamePkg::blockDamage : gamePkg::punchDamage;
		nextHealth = (health > damage) ? health - damage : 8'd0;  // saturate at 0
	end

	// ================================================
	// frame update
	// ================================================
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			posX     <= homeX;
			height   <= '0;
			stance   <= gamePkg::stand;
			health   <= gamePkg::healthMax;
			frameCnt <= '0;
		end else if (frameTick && stance != gamePkg::knockedOut && !gameOver) begin
			if (ko) begin
				stance <= gamePkg::knockedOut;
				height <= '0;  // drops to the floor
			end else begin
				if (hit)
					health <= nextHealth;
				posX <= nextX;

				case (stance)
					gamePkg::jump: begin
						if (frameCnt > (gamePkg::jumpFrames >> 1)) begin
							height <= height + gamePkg::jumpRise;  // rising half
						end else if (height <= gamePkg::jumpRise) begin
							height <= '0;
							stance <= gamePkg::stand;  // landed
						end else begin
							height <= height - gamePkg::jumpRise;
						end
						frameCnt <= frameCnt - 4'd1;
					end
					gamePkg::punch: begin
						if (frameCnt == 4'd0)
							stance <= gamePkg::stand;
						else
							frameCnt <= frameCnt - 4'd1;
					end
					default: begin
						// idle, pick the next action
						if (actPunch) begin
							stance   <= gamePkg::punch;
							frameCnt <= gamePkg::punchFrames - 4'd1;
						end else if (actJump) begin
							stance   <= gamePkg::jump;
							frameCnt <= gamePkg::jumpFrames - 4'd1;
							height   <= gamePkg::jumpRise;
						end else if (actCrouch) begin
							stance <= gamePkg::crouch;
						end else if (startWalk) begin
							stance <= gamePkg::walk;
						end else begin
							stance <= gamePkg::stand;
						end
					end
				endcase
			end
		end
	end

endmodule

/* logic/gamePkg.sv */
// ================================================
// arena geometry and movement step sizes
// combat reach, damage and health limits
// fighter stance encoding
// ================================================
package gamePkg;

	// ================================================
	// arena
	// ================================================
	localparam int numPlayers = 2;
	localparam logic [9:0] xMin = 10'd16;   // left wall
	localparam logic [9:0] xMax = 10'd600;  // right wall
	// player 0 at 200, player 1 at 400
	localparam logic [numPlayers-1:0][9:0] startX = {10'd400, 10'd200};

	// ================================================
	// movement and combat
	// ================================================
	localparam logic [9:0] walkStep = 10'd2;  // pixels per frame
	localparam logic [5:0] jumpRise = 6'd4;
	localparam logic [3:0] jumpFrames = 4'd8;  // 4 up, 4 down
	localparam logic [3:0] punchFrames = 4'd4;
	localparam logic [9:0] reach = 10'd40;
	localparam logic [9:0] knockStep = 10'd8;

	localparam logic [7:0] healthMax = 8'd128;
	localparam logic [7:0] punchDamage = 8'd16;
	localparam logic [7:0] blockDamage = 8'd4;  // chip damage through a crouch

	typedef enum logic [2:0] {
		stand,
		walk,
		jump,
		crouch,
		punch,
		knockedOut
	} stanceT;

endpackage

/* logic/keyDecoder.sv */
// ================================================
// four-phase req/ack capture of the host keycodes
// decode into held per-player action levels
// ================================================
`timescale 1ns/1ps

module keyDecoder (
	input  logic Clk,
	input  logic rstN,
	input  logic keyReq,
	input  keyPkg::keyCodeT keyCode [keyPkg::keySlots],
	output logic keyAck,
	output logic actLeft [gamePkg::numPlayers],
	output logic actRight [gamePkg::numPlayers],
	output logic actJump [gamePkg::numPlayers],
	output logic actCrouch [gamePkg::numPlayers],
	output logic actPunch [gamePkg::numPlayers]
);

	typedef enum logic {hsIdle, hsAcked} hsStateT;

	hsStateT state;
	logic capture;
	logic seenLeft [gamePkg::numPlayers];
	logic seenRight [gamePkg::numPlayers];
	logic seenJump [gamePkg::numPlayers];
	logic seenCrouch [gamePkg::numPlayers];
	logic seenPunch [gamePkg::numPlayers];

	// true if any slot carries the code
	function automatic logic hasKey(input keyPkg::keyCodeT slots [keyPkg::keySlots],
			input keyPkg::keyCodeT code);
		logic found;
		found = 1'b0;
		for (int s = 0; s < keyPkg::keySlots; s++) begin
			if (slots[s] == code)
				found = 1'b1;
		end
		return found;
	endfunction

	assign capture = (state == hsIdle) && keyReq;
	assign keyAck = (state == hsAcked);

	always_comb begin
		seenLeft[0]   = hasKey(keyCode, keyPkg::keyA);
		seenRight[0]  = hasKey(keyCode, keyPkg::keyD);
		seenJump[0]   = hasKey(keyCode, keyPkg::keyW);
		seenCrouch[0] = hasKey(keyCode, keyPkg::keyS);
		seenPunch[0]  = hasKey(keyCode, keyPkg::keyF);
		seenLeft[1]   = hasKey(keyCode, keyPkg::keyLeft);
		seenRight[1]  = hasKey(keyCode, keyPkg::keyRight);
		seenJump[1]   = hasKey(keyCode, keyPkg::keyUp);
		seenCrouch[1] = hasKey(keyCode, keyPkg::keyDown);
		seenPunch[1]  = hasKey(keyCode, keyPkg::keyL);
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			state <= hsIdle;
			for (int p = 0; p < gamePkg::numPlayers; p++) begin
				actLeft[p]   <= 1'b0;
				actRight[p]  <= 1'b0;
				actJump[p]   <= 1'b0;
				actCrouch[p] <= 1'b0;
				actPunch[p]  <= 1'b0;
			end
		end else begin
			if (capture) begin
				state <= hsAcked;  // ack rises with the capture
				for (int p = 0; p < gamePkg::numPlayers; p++) begin
					// opposite directions cancel
					actLeft[p]   <= seenLeft[p] & ~seenRight[p];
					actRight[p]  <= seenRight[p] & ~seenLeft[p];
					actJump[p]   <= seenJump[p];
					actCrouch[p] <= seenCrouch[p];
					actPunch[p]  <= seenPunch[p];
				end
			end else if (state == hsAcked && !keyReq) begin
				state <= hsIdle;
			end
		end
	end

endmodule

/* logic/keyPkg.sv */
// ================================================
// HID keycodes used by both players
// slot count of one host transfer
// ================================================
package keyPkg;

	localparam int keySlots = 4;  // keycodes per transfer

	// usage IDs from the HID keyboard page
	typedef enum logic [7:0] {
		keyNone  = 8'h00,  // empty slot

		// player 0, left side of the keyboard
		keyA     = 8'h04,
		keyD     = 8'h07,
		keyF     = 8'h09,
		keyS     = 8'h16,
		keyW     = 8'h1A,

		// player 1, arrows plus L
		keyL     = 8'h0F,
		keyRight = 8'h4F,
		keyLeft  = 8'h50,
		keyDown  = 8'h51,
		keyUp    = 8'h52
	} keyCodeT;

endpackage

/* run.sh */
#!/bin/sh
# build and run the fighter arena testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module fighterArenaTb -o fighterArenaSim

# pass or fail comes from the log
./obj_dir/fighterArenaSim > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH PASSED" sim.log

/* tests/fighterArenaTb.sv */
// ================================================
// arena testbench with a key table applied in a loop
// behavioural model, compare tasks, watchdog
// ================================================
`timescale 1ns/1ps

module fighterArenaTb;

	localparam int numRows = 16;
	localparam int ackLimit = 8;  // cycles per handshake edge

	logic Clk = 1'b0;
	logic rstN, frameTick, keyReq, keyAck, gameOver, winner;
	keyPkg::keyCodeT keyCode [keyPkg::keySlots];
	logic [9:0] posX [gamePkg::numPlayers];
	logic [5:0] height [gamePkg::numPlayers];
	gamePkg::stanceT stance [gamePkg::numPlayers];
	logic [7:0] health [gamePkg::numPlayers];

	// reference model state
	logic [9:0] mX [2];
	logic [5:0] mH [2];
	gamePkg::stanceT mSt [2];
	logic [7:0] mHp [2];
	int mAge [2];  // ticks since the jump or punch began
	logic mHit [2], mBlk [2], mPush [2];
	logic mL [2], mR [2], mJ [2], mC [2], mP [2];
	logic mGo, mWin, mAck, tickM, reqM, reqNext;
	keyPkg::keyCodeT codeM [keyPkg::keySlots];
	keyPkg::keyCodeT codeNext [keyPkg::keySlots];
	int cycleNo;
	int seed = 19003;

	keyPkg::keyCodeT leftKey [2] = '{keyPkg::keyA, keyPkg::keyLeft};
	keyPkg::keyCodeT rightKey [2] = '{keyPkg::keyD, keyPkg::keyRight};
	keyPkg::keyCodeT jumpKey [2] = '{keyPkg::keyW, keyPkg::keyUp};
	keyPkg::keyCodeT crouchKey [2] = '{keyPkg::keyS, keyPkg::keyDown};
	keyPkg::keyCodeT punchKey [2] = '{keyPkg::keyF, keyPkg::keyL};

	// ================================================
	// stimulus table with random idle rows at 0 frames
	// ================================================
	keyPkg::keyCodeT rowKeys [numRows][4] = '{
		'{keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyA, keyPkg::keyD, keyPkg::keyLeft, keyPkg::keyRight},  // cancel
		'{keyPkg::keyA, keyPkg::keyRight, keyPkg::keyNone, keyPkg::keyNone},  // to walls
		'{keyPkg::keyD, keyPkg::keyLeft, keyPkg::keyNone, keyPkg::keyNone},  // close in
		'{keyPkg::keyW, keyPkg::keyA, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyW, keyPkg::keyD, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyF, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyF, keyPkg::keyDown, keyPkg::keyNone, keyPkg::keyNone},  // blocked
		'{keyPkg::keyF, keyPkg::keyUp, keyPkg::keyNone, keyPkg::keyNone},  // airborne
		'{keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyA, keyPkg::keyRight, keyPkg::keyNone, keyPkg::keyNone},
		'{keyPkg::keyF, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone},  // out of reach
		'{keyPkg::keyL, keyPkg::keyD, keyPkg::keyNone, keyPkg::keyNone},  // walks into KO
		'{keyPkg::keyW, keyPkg::keyDown, keyPkg::keyA, keyPkg::keyRight},  // frozen
		'{keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone, keyPkg::keyNone}
	};
	int rowFrames [numRows] = '{2, 3, 105, 137, 8, 8, 6, 6, 10, 0, 0, 10, 5, 80, 8, 0};

	fighterArena dut (.*);

	always #20 Clk = ~Clk;

	// ================================================
	// compare tasks
	// ================================================
	task automatic abortRun();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkStance(input string name, input gamePkg::stanceT expVal,
			input gamePkg::stanceT actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH time=%0t %s expected=%s actual=%s", $time, name,
				expVal.name(), actVal.name());
			abortRun();
		end
	endtask

	task automatic checkValue(input string name, input logic [9:0] expVal,
			input logic [9:0] actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkHealth(input string name, input logic [7:0] expVal,
			input logic [7:0] actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			$display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, expVal, actVal);
			abortRun();
		end
	endtask

	task automatic compareAll();
		for (int p = 0; p < 2; p++) begin
			checkValue($sformatf("posX[%0d]", p), mX[p], posX[p]);
			checkValue($sformatf("height[%0d]", p), {4'd0, mH[p]}, {4'd0, height[p]});
			checkStance($sformatf("stance[%0d]", p), mSt[p], stance[p]);
			checkHealth($sformatf("health[%0d]", p), mHp[p], health[p]);
		end
		checkFlag("gameOver", mGo, gameOver);
		checkFlag("winner", mWin, winner);
		checkFlag("keyAck", mAck, keyAck);
	endtask

	// ================================================
	// reference model
	// ================================================
	function automatic logic pressed(input keyPkg::keyCodeT want);
		logic found;
		found = 1'b0;
		for (int s = 0; s < keyPkg::keySlots; s++)
			if (codeM[s] == want)
				found = 1'b1;
		return found;
	endfunction

	function automatic logic [9:0] moveX(input logic [9:0] x, input logic [9:0] d,
			input logic left);
		if (left)
			return (x - gamePkg::xMin < d) ? gamePkg::xMin : x - d;
		return (gamePkg::xMax - x < d) ? gamePkg::xMax : x + d;
	endfunction

	// triangle rising for half the jump and falling for the rest
	function automatic logic [5:0] jumpHeight(input int age);
		int half;
		half = int'(gamePkg::jumpFrames) / 2;
		if (age < half)
			return 6'(age + 1) * gamePkg::jumpRise;
		return 6'(2 * half - 1 - age) * gamePkg::jumpRise;
	endfunction

	task automatic modelStep();
		logic nHit [2];
		logic nBlk [2];
		logic nPush [2];
		logic nGo, nWin, close, grounded, idle, walking;
		logic [7:0] dmg;
		if (tickM) begin
			close = ((mX[0] > mX[1]) ? mX[0] - mX[1] : mX[1] - mX[0]) <= gamePkg::reach;
			grounded = (mH[0] == 6'd0) && (mH[1] == 6'd0);
			nGo = mGo;
			nWin = mWin;
			for (int v = 0; v < 2; v++) begin
				nHit[v] = !mGo && close && grounded && (mSt[1-v] == gamePkg::punch)
					&& (mAge[1-v] == 0);
				nBlk[v] = (mSt[v] == gamePkg::crouch);
				nPush[v] = (mX[v] < mX[1-v]);
			end
			if (!mGo && (mHp[0] == 8'd0 || mHp[1] == 8'd0)) begin
				nGo = 1'b1;
				nWin = (mHp[0] == 8'd0) && (mHp[1] != 8'd0);  // survivor wins and a tie goes to 0
			end
			for (int p = 0; p < 2; p++) begin
				if (mSt[p] == gamePkg::knockedOut || mGo) begin
					// frozen
				end else if (mHp[p] == 8'd0) begin
					mSt[p] = gamePkg::knockedOut;
					mH[p] = 6'd0;
				end else begin
					if (mHit[p]) begin
						dmg = mBlk[p] ? gamePkg::blockDamage : gamePkg::punchDamage;
						mHp[p] = (mHp[p] > dmg) ? mHp[p] - dmg : 8'd0;
					end
					idle = (mSt[p] == gamePkg::stand) || (mSt[p] == gamePkg::walk)
						|| (mSt[p] == gamePkg::crouch);
					walking = (mL[p] || mR[p]) && ((mSt[p] == gamePkg::jump)
						|| (idle && !mP[p] && !mJ[p] && !mC[p]));
					if (mHit[p] && !mBlk[p])
						mX[p] = moveX(mX[p], gamePkg::knockStep, mPush[p]);
					else if (walking)
						mX[p] = moveX(mX[p], gamePkg::walkStep, mL[p]);
					if (mSt[p] == gamePkg::jump) begin
						mAge[p]++;
						mH[p] = jumpHeight(mAge[p]);
						if (mAge[p] == int'(gamePkg::jumpFrames) - 1)
							mSt[p] = gamePkg::stand;  // landed
					end else if (mSt[p] == gamePkg::punch) begin
						if (mAge[p] == int'(gamePkg::punchFrames) - 1)
							mSt[p] = gamePkg::stand;
						else
							mAge[p]++;
					end else if (mP[p]) begin
						mSt[p] = gamePkg::punch;
						mAge[p] = 0;
					end else if (mJ[p]) begin
						mSt[p] = gamePkg::jump;
						mAge[p] = 0;
						mH[p] = jumpHeight(0);
					end else if (mC[p]) begin
						mSt[p] = gamePkg::crouch;
					end else begin
						mSt[p] = (mL[p] || mR[p]) ? gamePkg::walk : gamePkg::stand;
					end
				end
			end
			mHit = nHit;
			mBlk = nBlk;
			mPush = nPush;
			mGo = nGo;
			mWin = nWin;
		end
		// handshake runs every cycle after the fighters used the old actions
		if (!mAck && reqM) begin
			mAck = 1'b1;
			for (int p = 0; p < 2; p++) begin
				mL[p] = pressed(leftKey[p]) && !pressed(rightKey[p]);
				mR[p] = pressed(rightKey[p]) && !pressed(leftKey[p]);
				mJ[p] = pressed(jumpKey[p]);
				mC[p] = pressed(crouchKey[p]);
				mP[p] = pressed(punchKey[p]);
			end
		end else if (mAck && !reqM) begin
			mAck = 1'b0;
		end
	endtask

	// ================================================
	// cycle driver and host handshake
	// ================================================
	task automatic runCycle();
		@(posedge Clk);
		modelStep();
		tickM = (cycleNo % 4 == 3);
		reqM = reqNext;
		frameTick <= tickM;
		keyReq <= reqNext;
		for (int s = 0; s < keyPkg::keySlots; s++) begin
			codeM[s] = codeNext[s];
			keyCode[s] <= codeNext[s];
		end
		cycleNo++;
		@(negedge Clk);
		compareAll();
	endtask

	task automatic ackTimeout(input string what);
		$display("ERROR: keyAck did not %s within %0d cycles", what, ackLimit);
		abortRun();
	endtask

	task automatic sendKeys(input int row);
		int waited;
		for (int s = 0; s < keyPkg::keySlots; s++)
			codeNext[s] = rowKeys[row][s];
		reqNext = 1'b1;
		waited = 0;
		runCycle();
		while (keyAck !== 1'b1) begin
			if (waited == ackLimit)
				ackTimeout("rise after keyReq went high");
			runCycle();
			waited++;
		end
		reqNext = 1'b0;
		waited = 0;
		runCycle();
		while (keyAck !== 1'b0) begin
			if (waited == ackLimit)
				ackTimeout("drop after keyReq went low");
			runCycle();
			waited++;
		end
	endtask

	// watchdog allows 4 cycles of 40 ns per frame plus handshake slack
	initial begin : watchdog
		int limitNs;
		limitNs = 5000;
		for (int r = 0; r < numRows; r++)
			limitNs += 4 * 40 * ((rowFrames[r] == 0) ? 6 : rowFrames[r] + 2);
		#(limitNs);
		$display("ERROR: watchdog expired after %0d ns before the table finished", limitNs);
		abortRun();
	end

	initial begin
		int frames;
		rstN = 1'b0;
		frameTick = 1'b0;
		keyReq = 1'b0;
		reqNext = 1'b0;
		reqM = 1'b0;
		tickM = 1'b0;
		cycleNo = 0;
		for (int s = 0; s < keyPkg::keySlots; s++) begin
			keyCode[s] = keyPkg::keyNone;
			codeM[s] = keyPkg::keyNone;
			codeNext[s] = keyPkg::keyNone;
		end
		for (int p = 0; p < 2; p++) begin
			mX[p] = gamePkg::startX[p];
			mH[p] = 6'd0;
			mSt[p] = gamePkg::stand;
			mHp[p] = gamePkg::healthMax;
			mAge[p] = 0;
			{mHit[p], mBlk[p], mPush[p]} = 3'b000;
			{mL[p], mR[p], mJ[p], mC[p], mP[p]} = 5'b00000;
		end
		mGo = 1'b0;
		mWin = 1'b0;
		mAck = 1'b0;

		repeat (5) @(posedge Clk);
		rstN <= 1'b1;
		@(negedge Clk);
		compareAll();  // reset values

		for (int r = 0; r < numRows; r++) begin
			frames = rowFrames[r];
			if (frames == 0)
				frames = 1 + int'($unsigned($random(seed)) % 4);
			sendKeys(r);
			repeat (frames * 4) runCycle();
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
